// ==== tb.f ====
hw/ifu_pkg.sv
hw/ifu_precode.sv
hw/ifu_line_store.sv
hw/ifu_br_scan.sv
hw/ifu_fetch_top.sv
test/ifu_fetch_chk.sv
test/ifu_fetch_tb.sv

// ==== test/ifu_fetch_tb.sv ====
// Testbench for the instruction fetch front end.
// Refills lines into the four slots, fetches them back and compares every
// accepted response with a shadow model of the line store. Phases cover
// reset, random fill, branch scan, back-pressure, refill/fetch contention
// and retagging of a slot.

`timescale 1ns/10ps
`default_nettype none

module ifu_fetch_tb;

  localparam int TMO = 200;   // cycles allowed for any single wait

  logic                 forever_cpuclk = 1'b0;
  logic                 rst_n;
  logic                 refill_valid;
  ifu_pkg::refill_req_t refill_req;
  logic                 refill_ready;
  logic                 fetch_req_valid;
  ifu_pkg::pc_t         fetch_pc;
  logic                 fetch_req_ready;
  logic                 rsp_valid;
  ifu_pkg::fetch_rsp_t  rsp;
  logic                 rsp_ready;

  // shadow of the line store
  logic                 sh_valid [ifu_pkg::LINE_NUM];
  ifu_pkg::line_tag_t   sh_tag   [ifu_pkg::LINE_NUM];
  ifu_pkg::line_t       sh_data  [ifu_pkg::LINE_NUM];

  ifu_pkg::fetch_rsp_t  exp_q[$];   // expected responses in request order
  string                name_q[$];
  ifu_pkg::pc_t         pc_q[$];    // pcs still to be issued
  string                test_name;
  logic                 bp_mode;    // random rsp_ready when set
  int                   refill_waits;

  always #5 forever_cpuclk = ~forever_cpuclk;

  ifu_fetch_top uut (
    .forever_cpuclk  (forever_cpuclk),
    .rst_n           (rst_n),
    .refill_valid    (refill_valid),
    .refill_req      (refill_req),
    .refill_ready    (refill_ready),
    .fetch_req_valid (fetch_req_valid),
    .fetch_pc        (fetch_pc),
    .fetch_req_ready (fetch_req_ready),
    .rsp_valid       (rsp_valid),
    .rsp             (rsp),
    .rsp_ready       (rsp_ready)
  );

  // ========================================================================
  // reference model
  // ========================================================================
  // word k is {halfword 2k+1, halfword 2k}, halfword 0 at the top
  function automatic ifu_pkg::inst_t word_of(ifu_pkg::line_t line, int k);
    return {line[111-32*k -: 16], line[127-32*k -: 16]};
  endfunction

  function automatic logic is_br(ifu_pkg::inst_t inst);
    logic br;
    case (inst[31:26])
      ifu_pkg::OP_BCZ: br = (inst[9] == 1'b0);   // sel 00 or 01
      ifu_pkg::OP_BEQZ, ifu_pkg::OP_BNEZ, ifu_pkg::OP_B, ifu_pkg::OP_BL,
      ifu_pkg::OP_BEQ, ifu_pkg::OP_BNE, ifu_pkg::OP_BLT, ifu_pkg::OP_BGE,
      ifu_pkg::OP_BLTU, ifu_pkg::OP_BGEU: br = 1'b1;
      default: br = 1'b0;
    endcase
    return br;
  endfunction

  function automatic logic is_jmp(ifu_pkg::inst_t inst);
    return (inst[31:26] == ifu_pkg::OP_B) || (inst[31:26] == ifu_pkg::OP_BL);
  endfunction

  function automatic ifu_pkg::precode_t ref_precode(ifu_pkg::line_t line);
    ifu_pkg::precode_t pre;
    ifu_pkg::inst_t    inst;
    for (int h = 0; h < 8; h++) begin
      inst = word_of(line, h / 2);
      if (h % 2 == 0) pre[31-4*h -: 4] = {is_jmp(inst), is_br(inst), 1'b1, h != 0};
      else            pre[31-4*h -: 4] = {3'b000, h == 1};   // bry0 only on halfword 1
    end
    return pre;
  endfunction

  function automatic ifu_pkg::fetch_rsp_t expect_rsp(ifu_pkg::pc_t pc);
    ifu_pkg::fetch_rsp_t r;
    ifu_pkg::inst_t      inst;
    logic [31:0]         offs;
    int                  idx;
    int                  start;
    r     = '0;
    idx   = pc[5:4];
    start = pc[3:2];
    if (!sh_valid[idx] || sh_tag[idx] != pc[31:6]) return r;
    r.hit     = 1'b1;
    r.data    = sh_data[idx];
    r.precode = ref_precode(sh_data[idx]);
    for (int k = start; k < 4; k++) begin
      inst = word_of(r.data, k);
      if (!r.br_found && is_br(inst)) begin
        r.br_found  = 1'b1;
        r.br_word   = ifu_pkg::word_idx_t'(k);
        r.br_uncond = is_jmp(inst);
        case (inst[31:26])
          ifu_pkg::OP_B, ifu_pkg::OP_BL:
            offs = {{6{inst[9]}}, inst[9:0], inst[25:10]};
          ifu_pkg::OP_BEQZ, ifu_pkg::OP_BNEZ, ifu_pkg::OP_BCZ:
            offs = {{11{inst[4]}}, inst[4:0], inst[25:10]};
          default:
            offs = {{16{inst[25]}}, inst[25:10]};
        endcase
        r.br_target = {pc[31:4], 4'h0} + 32'(4 * k) + (offs << 2);
      end
    end
    return r;
  endfunction

  // ========================================================================
  // compare tasks
  // ========================================================================
  task automatic report_fail(string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) report_fail($sformatf("FAIL %s: expected %b actual %b", name, exp, act));
  endtask

  task automatic check_pc(string name, ifu_pkg::pc_t exp, ifu_pkg::pc_t act);
    if (exp !== act) report_fail($sformatf("FAIL %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_precode(string name, ifu_pkg::precode_t exp, ifu_pkg::precode_t act);
    if (exp !== act) report_fail($sformatf("FAIL %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_rsp(string name, ifu_pkg::fetch_rsp_t exp, ifu_pkg::fetch_rsp_t act);
    check_bit({name, ".hit"}, exp.hit, act.hit);
    if (exp.data !== act.data)
      report_fail($sformatf("FAIL %s.data: expected %h actual %h", name, exp.data, act.data));
    check_precode({name, ".precode"}, exp.precode, act.precode);
    check_bit({name, ".br_found"}, exp.br_found, act.br_found);
    check_bit({name, ".br_uncond"}, exp.br_uncond, act.br_uncond);
    check_pc({name, ".br_target"}, exp.br_target, act.br_target);
    if (exp !== act)   // catches br_word too
      report_fail($sformatf("FAIL %s: expected %h actual %h", name, exp, act));
  endtask

  // ========================================================================
  // monitor, sampled on the rising edge
  // ========================================================================
  always @(posedge forever_cpuclk) begin
    if (rst_n) begin
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) report_fail("response returned with no request outstanding");
        else begin
          check_rsp(name_q.pop_front(), exp_q.pop_front(), rsp);
        end
      end
      if (rsp_valid && !rsp_ready) check_bit({test_name, ".hold_ready"}, 1'b0, fetch_req_ready);
      if (fetch_req_valid && fetch_req_ready) begin
        check_bit({test_name, ".refill_ready"}, 1'b0, refill_ready);
        exp_q.push_back(expect_rsp(fetch_pc));
        name_q.push_back(test_name);
      end
      if (refill_valid && refill_ready) begin   // shadow follows the handshake
        sh_valid[refill_req.addr[5:4]] = 1'b1;
        sh_tag[refill_req.addr[5:4]]   = refill_req.addr[31:6];
        sh_data[refill_req.addr[5:4]]  = refill_req.data;
      end
    end
  end

  // a failed bound assertion stops the run at the next edge
  always @(posedge forever_cpuclk) begin
    if (uut.u_fetch_chk.n_fail != 0)
      report_fail("bound assertion failed in the fetch checker");
  end

  always @(negedge forever_cpuclk) rsp_ready = bp_mode ? (($urandom % 2) == 1) : 1'b1;

  // ========================================================================
  // stimulus tasks, driven on the falling edge
  // ========================================================================
  task automatic refill(ifu_pkg::pc_t addr, ifu_pkg::line_t data);
    int n;
    @(negedge forever_cpuclk);
    refill_valid    = 1'b1;
    refill_req.addr = addr;
    refill_req.data = data;
    n = 0;
    @(posedge forever_cpuclk);
    while (!refill_ready) begin
      n++;
      if (n > TMO) report_fail("timeout waiting for refill_ready");
      @(posedge forever_cpuclk);
    end
    refill_waits = n;
    @(negedge forever_cpuclk);
    refill_valid = 1'b0;
  endtask

  // issues everything in pc_q back to back
  task automatic issue_fetches();
    int n;
    while (pc_q.size() > 0) begin
      @(negedge forever_cpuclk);
      fetch_req_valid = 1'b1;
      fetch_pc        = pc_q.pop_front();
      n = 0;
      @(posedge forever_cpuclk);
      while (!fetch_req_ready) begin
        n++;
        if (n > TMO) report_fail("timeout waiting for fetch_req_ready");
        @(posedge forever_cpuclk);
      end
    end
    @(negedge forever_cpuclk);
    fetch_req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 || rsp_valid) begin
      n++;
      if (n > TMO) report_fail("timeout waiting for outstanding fetch responses");
      @(negedge forever_cpuclk);
    end
  endtask

  function automatic ifu_pkg::inst_t mk_inst(logic [5:0] op, logic [1:0] sel);
    ifu_pkg::inst_t i;
    i = {op, 26'($urandom)};
    if (op == ifu_pkg::OP_BCZ) i[9:8] = sel;
    return i;
  endfunction

  function automatic ifu_pkg::line_t pack_line(ifu_pkg::inst_t w0, ifu_pkg::inst_t w1,
                                               ifu_pkg::inst_t w2, ifu_pkg::inst_t w3);
    return {w0[15:0], w0[31:16], w1[15:0], w1[31:16],
            w2[15:0], w2[31:16], w3[15:0], w3[31:16]};
  endfunction

  // ========================================================================
  // test sequence
  // ========================================================================
  initial begin
    ifu_pkg::pc_t   base [4];
    ifu_pkg::line_t lines [4];
    ifu_pkg::pc_t   a;
    void'($urandom(87467));
    rst_n           = 1'b0;
    refill_valid    = 1'b0;
    refill_req      = '0;
    fetch_req_valid = 1'b0;
    fetch_pc        = '0;
    rsp_ready       = 1'b1;
    bp_mode         = 1'b0;
    test_name       = "reset";
    for (int s = 0; s < 4; s++) sh_valid[s] = 1'b0;
    repeat (10) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    rst_n = 1'b1;

    test_name = "reset_miss";
    for (int i = 0; i < 8; i++) pc_q.push_back($urandom);
    issue_fetches();
    wait_drain();

    test_name = "random_fill";
    for (int s = 0; s < 4; s++) begin
      base[s] = {26'($urandom), 2'(s), 4'h0};
      refill(base[s], {$urandom, $urandom, $urandom, $urandom});
    end
    for (int s = 0; s < 4; s++)
      for (int w = 0; w < 4; w++) pc_q.push_back(base[s] + 4 * w);
    issue_fetches();
    wait_drain();

    test_name = "branch_scan";
    lines[0] = pack_line(mk_inst(6'h00, 0), mk_inst(ifu_pkg::OP_BEQ, 0),
                         mk_inst(ifu_pkg::OP_BCZ, 2'b10), mk_inst(ifu_pkg::OP_BL, 0));
    lines[1] = pack_line(mk_inst(ifu_pkg::OP_BCZ, 2'b00), mk_inst(ifu_pkg::OP_B, 0),
                         mk_inst(ifu_pkg::OP_BNEZ, 0), mk_inst(ifu_pkg::OP_BLTU, 0));
    lines[2] = pack_line(mk_inst(ifu_pkg::OP_BGEU, 0), mk_inst(ifu_pkg::OP_BCZ, 2'b10),
                         mk_inst(ifu_pkg::OP_BCZ, 2'b01), mk_inst(6'h3f, 0));
    lines[3] = pack_line(mk_inst(ifu_pkg::OP_BNE, 0), mk_inst(ifu_pkg::OP_BLT, 0),
                         mk_inst(ifu_pkg::OP_BGE, 0), mk_inst(ifu_pkg::OP_BEQZ, 0));
    for (int s = 0; s < 4; s++) begin
      base[s] = {26'($urandom), 2'(s), 4'h0};
      refill(base[s], lines[s]);
    end
    for (int s = 0; s < 4; s++)
      for (int w = 0; w < 4; w++) pc_q.push_back(base[s] + 4 * w + ($urandom % 4));
    issue_fetches();
    wait_drain();

    test_name = "backpressure";
    bp_mode = 1'b1;
    for (int i = 0; i < 32; i++)
      pc_q.push_back((i % 5 == 4) ? ifu_pkg::pc_t'($urandom) : base[i % 4] + 4 * (i % 3));
    issue_fetches();
    wait_drain();
    bp_mode = 1'b0;

    // fetch burst to slot 1 while slot 1 is refilled with a new tag
    test_name = "refill_contention";
    a = {26'($urandom), 2'd1, 4'h0};
    for (int i = 0; i < 8; i++) pc_q.push_back(base[1] + 4 * (i % 4));
    fork
      issue_fetches();
      refill(a, {$urandom, $urandom, $urandom, $urandom});
    join
    check_bit("refill_contention.stalled", 1'b1, refill_waits >= 8);
    wait_drain();
    pc_q.push_back(a + 4);
    issue_fetches();
    wait_drain();

    test_name = "retag";
    a = {base[2][31:6] ^ 26'h1, 2'd2, 4'h0};
    pc_q.push_back(base[2]);
    issue_fetches();
    refill(a, {$urandom, $urandom, $urandom, $urandom});
    pc_q.push_back(base[2] + 8);   // old tag, now a miss
    pc_q.push_back(a + 8);
    issue_fetches();
    wait_drain();

    if (uut.u_fetch_chk.n_fail != 0) begin
      report_fail("bound assertion failed in the fetch checker");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/ifu_fetch_chk.sv ====
// Assertion checker bound to the fetch front end top level.
// Covers the handshake outputs after a reset edge, response stability
// under back-pressure and refill_ready against fetch accepts.

`timescale 1ns/10ps
`default_nettype none

module ifu_fetch_chk (
  input wire                      forever_cpuclk,
  input wire                      rst_n,
  input wire                      refill_ready,
  input wire                      fetch_req_valid,
  input wire                      fetch_req_ready,
  input wire                      rsp_valid,
  input wire                      rsp_ready,
  input wire ifu_pkg::fetch_rsp_t rsp
);

  int n_fail = 0;   // failed assertion count

  // ========================================================================
  // handshake properties
  // ========================================================================
  a_reset_quiet: assert property (@(posedge forever_cpuclk)
    !rst_n |=> (!rsp_valid && !fetch_req_ready && !refill_ready))
    else begin
      n_fail++;
      $error("handshake output high after a reset edge");
    end

  // held response must not move
  a_rsp_hold: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else begin
      n_fail++;
      $error("fetch response changed while held");
    end

  // fetch owns the port, refill gets it in every other cycle
  a_refill_stall: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    $past(rst_n) |-> (refill_ready == !(fetch_req_valid && fetch_req_ready)))
    else begin
      n_fail++;
      $error("refill_ready does not follow the fetch accept");
    end

endmodule

bind ifu_fetch_top ifu_fetch_chk u_fetch_chk (
  .forever_cpuclk  (forever_cpuclk),
  .rst_n           (rst_n),
  .refill_ready    (refill_ready),
  .fetch_req_valid (fetch_req_valid),
  .fetch_req_ready (fetch_req_ready),
  .rsp_valid       (rsp_valid),
  .rsp_ready       (rsp_ready),
  .rsp             (rsp)
);

`default_nettype wire

// ==== hw/ifu_fetch_top.sv ====
// Top level of the instruction fetch front end.
// Refill writes a line and its precode into the line store; fetch looks up
// a pc, checks the tag and scans for the first branch. The single store
// port goes to fetch first. Fetch responses come one cycle after the
// request is accepted and hold until rsp_ready.

`timescale 1ns/10ps
`default_nettype none

module ifu_fetch_top (
  input  wire                       forever_cpuclk,
  input  wire                       rst_n,
  // refill port
  input  wire                       refill_valid,
  input  wire ifu_pkg::refill_req_t refill_req,
  output logic                      refill_ready,
  // fetch request port
  input  wire                       fetch_req_valid,
  input  wire ifu_pkg::pc_t         fetch_pc,
  output logic                      fetch_req_ready,
  // fetch response port
  output logic                      rsp_valid,
  output ifu_pkg::fetch_rsp_t       rsp,
  input  wire                       rsp_ready
);

  logic                port_en_q;       // ports closed through reset
  logic                fetch_acc;
  logic                refill_acc;
  ifu_pkg::precode_t   refill_precode;
  logic                rd_valid;
  ifu_pkg::line_tag_t  rd_tag;
  ifu_pkg::line_t      rd_data;
  ifu_pkg::precode_t   rd_precode;
  logic                hit;
  ifu_pkg::pc_t        line_base;
  logic                br_found;
  ifu_pkg::word_idx_t  br_word;
  logic                br_uncond;
  ifu_pkg::pc_t        br_target;
  ifu_pkg::fetch_rsp_t rsp_d;

  // ========================================================================
  // handshake and arbitration
  // ========================================================================
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) port_en_q <= 1'b0;
    else        port_en_q <= 1'b1;
  end

  assign fetch_req_ready = port_en_q && !(rsp_valid && !rsp_ready);  // stall while held
  assign fetch_acc       = fetch_req_valid && fetch_req_ready;
  assign refill_ready    = port_en_q && !fetch_acc;                  // fetch wins the port
  assign refill_acc      = refill_valid && refill_ready;

  // ========================================================================
  // datapath
  // ========================================================================
  ifu_precode u_precode (
    .inst_data (refill_req.data),
    .pre_code  (refill_precode)
  );

  ifu_line_store u_line_store (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .wr_en          (refill_acc),
    .wr_idx         (ifu_pkg::line_idx_t'(refill_req.addr[5:4])),
    .wr_tag         (ifu_pkg::line_tag_t'(refill_req.addr[31:6])),
    .wr_data        (refill_req.data),
    .wr_precode     (refill_precode),
    .rd_idx         (ifu_pkg::line_idx_t'(fetch_pc[5:4])),
    .rd_valid       (rd_valid),
    .rd_tag         (rd_tag),
    .rd_data        (rd_data),
    .rd_precode     (rd_precode)
  );

  assign hit       = rd_valid && (rd_tag == fetch_pc[31:6]);
  assign line_base = {fetch_pc[31:4], 4'b0000};

  ifu_br_scan u_br_scan (
    .line_base  (line_base),
    .start_word (ifu_pkg::word_idx_t'(fetch_pc[3:2])),
    .data       (rd_data),
    .precode    (rd_precode),
    .br_found   (br_found),
    .br_word    (br_word),
    .br_uncond  (br_uncond),
    .br_target  (br_target)
  );

  // miss returns zeros apart from hit
  always_comb begin
    rsp_d     = '0;
    rsp_d.hit = hit;
    if (hit) begin
      rsp_d.data      = rd_data;
      rsp_d.precode   = rd_precode;
      rsp_d.br_found  = br_found;
      rsp_d.br_word   = br_word;
      rsp_d.br_uncond = br_uncond;
      rsp_d.br_target = br_target;
    end
  end

  // ========================================================================
  // response register
  // ========================================================================
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n)         rsp_valid <= 1'b0;
    else if (fetch_acc) rsp_valid <= 1'b1;
    else if (rsp_ready) rsp_valid <= 1'b0;
  end

  always_ff @(posedge forever_cpuclk) begin
    if (fetch_acc) rsp <= rsp_d;   // only loads when the slot is free
  end

endmodule

`default_nettype wire

// ==== hw/ifu_br_scan.sv ====
// Branch scan over one fetched line.
// Finds the lowest word at or after start_word whose stored precode marks a
// branch, and computes its target from line_base, the word offset and the
// immediate of that instruction. All outputs are zero when no branch is
// found. Purely combinational.

`timescale 1ns/10ps
`default_nettype none

module ifu_br_scan (
  input  wire ifu_pkg::pc_t       line_base,   // pc with bits 3:0 clear
  input  wire ifu_pkg::word_idx_t start_word,
  input  wire ifu_pkg::line_t     data,
  input  wire ifu_pkg::precode_t  precode,
  output logic                    br_found,
  output ifu_pkg::word_idx_t      br_word,
  output logic                    br_uncond,
  output ifu_pkg::pc_t            br_target
);

  logic [ifu_pkg::WORD_NUM-1:0] cand;     // br bit of each word, masked by start
  logic                         found;
  ifu_pkg::word_idx_t           sel;
  ifu_pkg::inst_t               inst;
  logic [5:0]                   op;
  logic                         uncond;
  logic                         cond21;   // beqz, bnez and the bcz forms
  ifu_pkg::pc_t                 offs;     // sign-extended, already shifted by 2

  // ========================================================================
  // pick the first branch word
  // ========================================================================
  always_comb begin
    found = 1'b0;
    sel   = '0;
    for (int k = 0; k < ifu_pkg::WORD_NUM; k++) begin
      // br is bit 2 of the even-halfword nibble
      cand[k] = precode[30 - 8*k] && (k >= int'(start_word));
    end
    // walk down so the lowest candidate wins
    for (int k = ifu_pkg::WORD_NUM - 1; k >= 0; k--) begin
      if (cand[k]) begin
        found = 1'b1;
        sel   = ifu_pkg::word_idx_t'(k);
      end
    end
  end

  // ========================================================================
  // immediate and target
  // ========================================================================
  always_comb begin
    inst   = ifu_pkg::line_word(data, sel);
    op     = inst[31:26];
    uncond = precode[31 - 8*int'(sel)];     // ab_br of the chosen word
    cond21 = (op == ifu_pkg::OP_BEQZ) ||
             (op == ifu_pkg::OP_BNEZ) ||
             (op == ifu_pkg::OP_BCZ);

    if (uncond) begin
      offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};    // offs26
    end else if (cond21) begin
      offs = {{9{inst[4]}}, inst[4:0], inst[25:10], 2'b00};    // offs21
    end else begin
      offs = {{14{inst[25]}}, inst[25:10], 2'b00};             // offs16
    end

    br_found  = 1'b0;
    br_word   = '0;
    br_uncond = 1'b0;
    br_target = '0;
    if (found) begin
      br_found  = 1'b1;
      br_word   = sel;
      br_uncond = uncond;
      br_target = line_base + ifu_pkg::pc_t'({sel, 2'b00}) + offs;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ifu_line_store.sv ====
// Four-entry line store of the fetch front end.
// Each slot keeps a valid bit, a tag, one 128-bit line and its precode.
// Writes land on the clock edge when wr_en is high; the read side returns
// the slot picked by rd_idx combinationally. Only valid bits are reset.

`timescale 1ns/10ps
`default_nettype none

module ifu_line_store (
  input  wire                     forever_cpuclk,
  input  wire                     rst_n,
  // write side, from refill
  input  wire                     wr_en,
  input  wire ifu_pkg::line_idx_t wr_idx,
  input  wire ifu_pkg::line_tag_t wr_tag,
  input  wire ifu_pkg::line_t     wr_data,
  input  wire ifu_pkg::precode_t  wr_precode,
  // read side, from fetch
  input  wire ifu_pkg::line_idx_t rd_idx,
  output logic                    rd_valid,
  output ifu_pkg::line_tag_t      rd_tag,
  output ifu_pkg::line_t          rd_data,
  output ifu_pkg::precode_t       rd_precode
);

  // ========================================================================
  // storage
  // ========================================================================
  logic [ifu_pkg::LINE_NUM-1:0] valid_q;
  ifu_pkg::line_tag_t           tag_q     [ifu_pkg::LINE_NUM];
  ifu_pkg::line_t               data_q    [ifu_pkg::LINE_NUM];
  ifu_pkg::precode_t            precode_q [ifu_pkg::LINE_NUM];

  // valid bits, cleared in reset
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;   // a refill always fills the whole line
    end
  end

  // payload
  always_ff @(posedge forever_cpuclk) begin
    if (wr_en) begin
      tag_q[wr_idx]     <= wr_tag;
      data_q[wr_idx]    <= wr_data;
      precode_q[wr_idx] <= wr_precode;
    end
  end

  // ========================================================================
  // read port
  // ========================================================================
  // same-edge write is not seen until the next cycle
  assign rd_valid   = valid_q[rd_idx];
  assign rd_tag     = tag_q[rd_idx];
  assign rd_data    = data_q[rd_idx];
  assign rd_precode = precode_q[rd_idx];

endmodule

`default_nettype wire

// ==== hw/ifu_precode.sv ====
// Precode of one 128-bit instruction line, run at refill time.
// Every even halfword is taken as the start of a 32-bit instruction. Each
// halfword gets a nibble {ab_br, br, bry1, bry0}; halfword 0 lands in
// pre_code[31:28] and halfword 7 in pre_code[3:0]. Purely combinational.

`timescale 1ns/10ps
`default_nettype none

module ifu_precode (
  input  wire ifu_pkg::line_t    inst_data,
  output ifu_pkg::precode_t      pre_code
);

  // ========================================================================
  // decode helpers
  // ========================================================================

  // any of the twelve branch encodings
  function automatic logic is_branch(ifu_pkg::inst_t inst);
    logic [5:0] op;
    logic       br;
    op = inst[31:26];
    case (op)
      ifu_pkg::OP_BEQZ,
      ifu_pkg::OP_BNEZ,
      ifu_pkg::OP_B,
      ifu_pkg::OP_BL,
      ifu_pkg::OP_BEQ,
      ifu_pkg::OP_BNE,
      ifu_pkg::OP_BLT,
      ifu_pkg::OP_BGE,
      ifu_pkg::OP_BLTU,
      ifu_pkg::OP_BGEU: br = 1'b1;
      // bceqz / bcnez only, other selects are not branches
      ifu_pkg::OP_BCZ:  br = (inst[9:8] == ifu_pkg::BCZ_SEL_EQZ) ||
                             (inst[9:8] == ifu_pkg::BCZ_SEL_NEZ);
      default:          br = 1'b0;
    endcase
    return br;
  endfunction

  // unconditional direct jumps
  function automatic logic is_jump(ifu_pkg::inst_t inst);
    logic [5:0] op;
    op = inst[31:26];
    return (op == ifu_pkg::OP_B) || (op == ifu_pkg::OP_BL);
  endfunction

  // ========================================================================
  // per-word precode
  // ========================================================================
  // nib[7] is halfword 0, nib[0] is halfword 7
  wire [7:0][3:0] nib;

  for (genvar w = 0; w < ifu_pkg::WORD_NUM; w++) begin : g_word
    ifu_pkg::inst_t word;
    logic           br;
    logic           ab_br;

    assign word  = ifu_pkg::line_word(inst_data, ifu_pkg::word_idx_t'(w));
    assign br    = is_branch(word);
    assign ab_br = is_jump(word);

    // even halfword, start of word w
    // bry1 always set, bry0 set from halfword 2 on
    assign nib[7-2*w] = {ab_br, br, 1'b1, (w != 0)};

    // odd halfword never holds a branch
    // bry0 only for halfword 1, the fixed boundary pattern
    assign nib[6-2*w] = {3'b000, (w == 0)};
  end

  assign pre_code = nib;

endmodule

`default_nettype wire

// ==== hw/ifu_pkg.sv ====
// Shared types and constants for the instruction fetch front end.
// Holds the pc, line and precode widths, the branch major opcodes and the
// refill request and fetch response structs. Every other file refers to
// these by scoped name.

`default_nettype none

package ifu_pkg;

  // ========================================================================
  // sizes and field types
  // ========================================================================
  localparam int LINE_NUM = 4;     // slots in the line store
  localparam int WORD_NUM = 4;     // 32-bit words per line

  typedef logic [31:0]  pc_t;
  typedef logic [31:0]  inst_t;
  typedef logic [127:0] line_t;      // halfword 0 sits in 127:112
  typedef logic [31:0]  precode_t;   // one {ab_br, br, bry1, bry0} nibble per halfword
  typedef logic [1:0]   line_idx_t;  // pc[5:4]
  typedef logic [25:0]  line_tag_t;  // pc[31:6]
  typedef logic [1:0]   word_idx_t;  // pc[3:2]

  // ========================================================================
  // branch major opcodes, inst[31:26]
  // ========================================================================
  localparam logic [5:0] OP_BEQZ = 6'b010000;
  localparam logic [5:0] OP_BNEZ = 6'b010001;
  localparam logic [5:0] OP_BCZ  = 6'b010010;  // bceqz / bcnez, split by inst[9:8]
  localparam logic [5:0] OP_B    = 6'b010100;
  localparam logic [5:0] OP_BL   = 6'b010101;
  localparam logic [5:0] OP_BEQ  = 6'b010110;
  localparam logic [5:0] OP_BNE  = 6'b010111;
  localparam logic [5:0] OP_BLT  = 6'b011000;
  localparam logic [5:0] OP_BGE  = 6'b011001;
  localparam logic [5:0] OP_BLTU = 6'b011010;
  localparam logic [5:0] OP_BGEU = 6'b011011;

  localparam logic [1:0] BCZ_SEL_EQZ = 2'b00;
  localparam logic [1:0] BCZ_SEL_NEZ = 2'b01;

  // ========================================================================
  // port structs
  // ========================================================================
  typedef struct packed {
    pc_t   addr;   // low 4 bits ignored
    line_t data;
  } refill_req_t;

  typedef struct packed {
    logic      hit;
    line_t     data;
    precode_t  precode;
    logic      br_found;
    word_idx_t br_word;
    logic      br_uncond;   // b or bl
    pc_t       br_target;
  } fetch_rsp_t;

  // word k of a line is {halfword 2k+1, halfword 2k}
  function automatic inst_t line_word(line_t line, word_idx_t k);
    int base;
    base = 127 - 32 * int'(k);
    return {line[base-16 -: 16], line[base -: 16]};
  endfunction

endpackage

`default_nettype wire
